// ==== Bender.yml ====
package:
  name: vector_slide

export_include_dirs:
  - .

sources:
  - sld_pkg.sv
  - sld_decode.sv
  - sld_execute.sv
  - sld_result.sv
  - sld_top.sv
  - target: test
    files:
      - tb_sld.sv

// ==== flist.f ====
+incdir+.
sld_pkg.sv
sld_decode.sv
sld_execute.sv
sld_result.sv
sld_top.sv
tb_sld.sv

// ==== sld_decode.sv ====
//////////////////////////////////////////////////////////////////////
// slide decode, turns one request into a control word per chunk
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "sld_settings.svh"

module sld_decode (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                req_valid_i,
    input  sld_pkg::sld_req_t   req_i,
    output logic                req_ready_o,
    output logic                ctrl_valid_o,
    output sld_pkg::sld_ctrl_t  ctrl_o,
    input  logic                ctrl_ready_i
);

    localparam int unsigned VB = `SLD_VREG_W / 8;     // register bytes
    localparam int unsigned OW = `SLD_OFFS_W;
    localparam int unsigned VW = `SLD_VL_W;
    localparam int unsigned KW = `SLD_OFFS_W + 2;
    localparam int unsigned CW = `SLD_CIDX_W;
    localparam int unsigned SW = `SLD_SHFT_W;

    if ((`SLD_OP_W & (`SLD_OP_W - 1)) != 0 || `SLD_OP_W < 32 || `SLD_OP_W >= `SLD_VREG_W) begin
        $fatal(1, "SLD_OP_W must be a power of two, at least 32 and below SLD_VREG_W");
    end

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e                     state_q;
    logic [CW-1:0]              cnt_q;
    sld_pkg::sld_req_t          req_q;
    logic signed [OW-1:0]       offs_q, offs_d;     // dest to source byte distance
    logic [VW-1:0]              vlb_q, vlb_d;
    logic [1:0]                 eew_shift;
    logic [KW-1:0]              k_bytes, vl_wide;
    logic signed [OW-1:0]       cnt_s, hi_s, lo_s;
    logic                       last_chunk, ctrl_fire, req_fire;

    //////////////////////////////////////////////////////////////////////
    // request acceptance

    assign last_chunk   = cnt_q == CW'(`SLD_CHUNKS - 1);
    assign ctrl_valid_o = state_q == RUN;
    assign ctrl_fire    = ctrl_valid_o & ctrl_ready_i;
    assign req_ready_o  = (state_q == IDLE) | (ctrl_fire & last_chunk);
    assign req_fire     = req_valid_i & req_ready_o;

    assign eew_shift = req_i.eew;   // log2 of element bytes

    always_comb begin
        // clamp the element offset to the register, then scale to bytes
        if (req_i.scalar < VB) begin
            k_bytes = KW'(req_i.scalar[VW-1:0]) << eew_shift;
        end else begin
            k_bytes = KW'(VB);
        end
        if (k_bytes > VB) begin
            k_bytes = KW'(VB);
        end
        unique case (req_i.op)
            sld_pkg::SLIDEUP:   offs_d =  k_bytes[OW-1:0];
            sld_pkg::SLIDEDOWN: offs_d = -k_bytes[OW-1:0];
            sld_pkg::SLIDE1UP:  offs_d =  OW'(1) << eew_shift;    // one element
            default:            offs_d = -(OW'(1) << eew_shift);
        endcase
        vl_wide = KW'(req_i.vl) << eew_shift;
        vlb_d   = (vl_wide > VB) ? VW'(VB) : vl_wide[VW-1:0];
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (req_fire) begin
            state_q <= RUN;
            cnt_q   <= '0;
        end else if (ctrl_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_chunk) begin
                state_q <= IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q  <= req_i;
            offs_q <= offs_d;
            vlb_q  <= vlb_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per chunk control word

    // high operand is the source chunk holding bytes at or above the shift
    assign cnt_s = OW'(cnt_q);
    assign hi_s  = cnt_s - (offs_q >>> SW);
    assign lo_s  = hi_s - 1;

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.op       = req_q.op;
        ctrl_o.eew      = req_q.eew;
        ctrl_o.chunk    = cnt_q;
        ctrl_o.shift    = offs_q[SW-1:0];
        ctrl_o.lo_idx   = lo_s[CW-1:0];
        ctrl_o.hi_idx   = hi_s[CW-1:0];
        ctrl_o.lo_valid = (lo_s >= 0) && (lo_s < `SLD_CHUNKS);
        ctrl_o.hi_valid = (hi_s >= 0) && (hi_s < `SLD_CHUNKS);
        ctrl_o.first    = cnt_q == '0;
        ctrl_o.last     = last_chunk;
        ctrl_o.vl_bytes = vlb_q;
        ctrl_o.scalar   = req_q.scalar;
        ctrl_o.masked   = req_q.masked;
        ctrl_o.vs2      = req_q.vs2;
        ctrl_o.vd_old   = req_q.vd_old;
        ctrl_o.v0       = req_q.v0;
    end

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        req_fire |-> req_i.eew inside {sld_pkg::EEW_8, sld_pkg::EEW_16, sld_pkg::EEW_32});

endmodule

// ==== sld_execute.sv ====
//////////////////////////////////////////////////////////////////////
// slide execute, selects and byte-shifts two source chunks into one
// result chunk, registered once toward the result stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "sld_settings.svh"

module sld_execute (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                ctrl_valid_i,
    input  sld_pkg::sld_ctrl_t  ctrl_i,
    output logic                ctrl_ready_o,
    output logic                chunk_valid_o,
    output sld_pkg::sld_chunk_t chunk_o,
    input  logic                chunk_ready_i
);

    localparam int unsigned CB = `SLD_CHUNK_B;
    localparam int unsigned OW = `SLD_OP_W;
    localparam int unsigned SW = `SLD_SHFT_W;
    localparam int unsigned AW = `SLD_VL_W;

    logic                   chunk_valid_q;
    sld_pkg::sld_chunk_t    chunk_q, chunk_d;
    logic [CB-1:0][7:0]     lo_op, hi_op, scal_rep, res_b;
    logic [CB-1:0]          src_valid, v0_chunk;
    logic [AW-1:0]          lo_addr, hi_addr;   // source byte address in the register
    logic                   is_s1up, is_s1dn;

    assign is_s1up = ctrl_i.op == sld_pkg::SLIDE1UP;
    assign is_s1dn = ctrl_i.op == sld_pkg::SLIDE1DOWN;

    always_comb begin
        unique case (ctrl_i.eew)
            sld_pkg::EEW_8:  scal_rep = {CB{ctrl_i.scalar[7:0]}};
            sld_pkg::EEW_16: scal_rep = {(CB/2){ctrl_i.scalar[15:0]}};
            default:         scal_rep = {(CB/4){ctrl_i.scalar}};
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // operand selection

    always_comb begin
        lo_op = ctrl_i.lo_valid ? ctrl_i.vs2[ctrl_i.lo_idx*OW +: OW] : '0;   // outside reads 0
        hi_op = ctrl_i.hi_valid ? ctrl_i.vs2[ctrl_i.hi_idx*OW +: OW] : '0;
        lo_addr = '0;
        hi_addr = '0;
        for (int p = 0; p < CB; p++) begin
            lo_addr = {1'b0, ctrl_i.lo_idx, SW'(p)};
            hi_addr = {1'b0, ctrl_i.hi_idx, SW'(p)};
            // slide1up only misses its source in front of the register
            if ((is_s1up & ctrl_i.first) | (is_s1dn & (lo_addr >= ctrl_i.vl_bytes))) begin
                lo_op[p] = scal_rep[p];
            end
            // slide1down takes the scalar from byte vl of the source stream on
            if (((is_s1up | is_s1dn) & ~ctrl_i.hi_valid) |
                (is_s1dn & (hi_addr >= ctrl_i.vl_bytes))) begin
                hi_op[p] = scal_rep[p];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // byte shifter

    always_comb begin
        for (int i = 0; i < CB; i++) begin
            if (i < ctrl_i.shift) begin
                res_b[i]     = lo_op[CB + i - ctrl_i.shift];
                src_valid[i] = ctrl_i.lo_valid;
            end else begin
                res_b[i]     = hi_op[i - ctrl_i.shift];
                src_valid[i] = ctrl_i.hi_valid;
            end
        end
        // only slideup leaves bytes untouched, slidedown writes zeros
        if (ctrl_i.op != sld_pkg::SLIDEUP) begin
            src_valid = '1;
        end
    end

    assign v0_chunk = ctrl_i.v0[ctrl_i.chunk*CB +: CB];

    always_comb begin
        chunk_d           = '0;
        chunk_d.idx       = ctrl_i.chunk;
        chunk_d.data      = res_b;
        chunk_d.src_valid = src_valid;
        chunk_d.last      = ctrl_i.last;
        chunk_d.vl_bytes  = ctrl_i.vl_bytes;
        chunk_d.masked    = ctrl_i.masked;
        chunk_d.vd_old    = ctrl_i.vd_old[ctrl_i.chunk*OW +: OW];
        for (int i = 0; i < CB; i++) begin
            chunk_d.v0[i] = v0_chunk[i & ~((1 << int'(ctrl_i.eew)) - 1)]; // element's first lane
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register

    assign ctrl_ready_o = ~chunk_valid_q | chunk_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            chunk_valid_q <= 1'b0;
        end else if (ctrl_ready_o) begin
            chunk_valid_q <= ctrl_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_valid_i & ctrl_ready_o) begin
            chunk_q <= chunk_d;
        end
    end

    assign chunk_valid_o = chunk_valid_q;
    assign chunk_o       = chunk_q;

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        chunk_valid_o & ~chunk_ready_i |=> chunk_valid_o & $stable(chunk_o));

endmodule

// ==== sld_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// opcodes, element widths and the words passed between the slide
// unit stages, shared by the RTL and the testbench
//////////////////////////////////////////////////////////////////////

`include "sld_settings.svh"

package sld_pkg;

    typedef enum logic [1:0] {
        SLIDEUP    = 2'd0,
        SLIDEDOWN  = 2'd1,
        SLIDE1UP   = 2'd2,
        SLIDE1DOWN = 2'd3
    } sld_op_e;

    // encoding equals log2 of the element size in bytes
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } sld_eew_e;

    typedef struct packed {
        sld_op_e                    op;
        sld_eew_e                   eew;
        logic [`SLD_VL_W-1:0]       vl;         // in elements
        logic                       masked;
        logic [31:0]                scalar;     // element offset or slide1 value
        logic [`SLD_VREG_W-1:0]     vs2;
        logic [`SLD_VREG_W-1:0]     vd_old;
        logic [`SLD_VREG_W/8-1:0]   v0;         // one bit per byte lane
    } sld_req_t;

    typedef struct packed {
        sld_op_e                    op;
        sld_eew_e                   eew;
        logic [`SLD_CIDX_W-1:0]     chunk;
        logic [`SLD_SHFT_W-1:0]     shift;
        logic [`SLD_CIDX_W-1:0]     lo_idx;
        logic [`SLD_CIDX_W-1:0]     hi_idx;
        logic                       lo_valid;
        logic                       hi_valid;
        logic                       first;
        logic                       last;
        logic [`SLD_VL_W-1:0]       vl_bytes;
        logic [31:0]                scalar;
        logic                       masked;
        logic [`SLD_VREG_W-1:0]     vs2;
        logic [`SLD_VREG_W-1:0]     vd_old;
        logic [`SLD_VREG_W/8-1:0]   v0;
    } sld_ctrl_t;

    typedef struct packed {
        logic [`SLD_CIDX_W-1:0]     idx;
        logic [`SLD_OP_W-1:0]       data;
        logic [`SLD_CHUNK_B-1:0]    src_valid;
        logic                       last;
        logic [`SLD_VL_W-1:0]       vl_bytes;
        logic                       masked;
        logic [`SLD_CHUNK_B-1:0]    v0;         // already spread per element
        logic [`SLD_OP_W-1:0]       vd_old;
    } sld_chunk_t;

    typedef struct packed {
        logic [`SLD_VREG_W-1:0]     vd;
    } sld_res_t;

endpackage

// ==== sld_result.sv ====
//////////////////////////////////////////////////////////////////////
// slide result, masks chunks into the destination and holds the
// finished vector until the result port takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "sld_settings.svh"

module sld_result (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                chunk_valid_i,
    input  sld_pkg::sld_chunk_t chunk_i,
    output logic                chunk_ready_o,
    output logic                res_valid_o,
    output sld_pkg::sld_res_t   res_o,
    input  logic                res_ready_i
);

    localparam int unsigned CB = `SLD_CHUNK_B;
    localparam int unsigned OW = `SLD_OP_W;
    localparam int unsigned NC = `SLD_CHUNKS;
    localparam int unsigned SW = `SLD_SHFT_W;
    localparam int unsigned AW = `SLD_VL_W;

    logic [NC-1:0][OW-1:0]  work_q;
    logic                   work_full_q;    // complete vector waiting to move
    logic                   out_valid_q;
    sld_pkg::sld_res_t      out_q;
    logic [CB-1:0][7:0]     merged;
    logic [AW-1:0]          byte_addr;
    logic                   move, chunk_fire;

    //////////////////////////////////////////////////////////////////////
    // tail and v0 masking

    always_comb begin
        byte_addr = '0;
        for (int i = 0; i < CB; i++) begin
            byte_addr = AW'({chunk_i.idx, SW'(i)});
            if (chunk_i.src_valid[i] & (byte_addr < chunk_i.vl_bytes) &
                (~chunk_i.masked | chunk_i.v0[i])) begin
                merged[i] = chunk_i.data[i*8 +: 8];
            end else begin
                merged[i] = chunk_i.vd_old[i*8 +: 8];     // keep old destination
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // working vector and output register

    assign move          = work_full_q & (~out_valid_q | res_ready_i);
    assign chunk_ready_o = ~work_full_q | move;
    assign chunk_fire    = chunk_valid_i & chunk_ready_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            work_full_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (chunk_fire & chunk_i.last) begin
                work_full_q <= 1'b1;
            end else if (move) begin
                work_full_q <= 1'b0;
            end
            if (move) begin
                out_valid_q <= 1'b1;
            end else if (res_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (chunk_fire) begin
            work_q[chunk_i.idx] <= merged;
        end
        if (move) begin
            out_q.vd <= work_q;
        end
    end

    assign res_valid_o = out_valid_q;
    assign res_o       = out_q;

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        res_valid_o & ~res_ready_i |=> res_valid_o & $stable(res_o));

endmodule

// ==== sld_settings.svh ====
//////////////////////////////////////////////////////////////////////
// sizes of the vector slide unit, included by the package and the RTL
//////////////////////////////////////////////////////////////////////

`ifndef SLD_SETTINGS_SVH
`define SLD_SETTINGS_SVH

`define SLD_VREG_W  128                               // vector register width in bits
`define SLD_OP_W    32                                // chunk width per cycle

`define SLD_CHUNKS  (`SLD_VREG_W / `SLD_OP_W)         // chunks per register
`define SLD_CHUNK_B (`SLD_OP_W / 8)                   // bytes per chunk

// vl holds up to the full register byte count
`define SLD_VL_W    ($clog2(`SLD_VREG_W / 8) + 1)
`define SLD_OFFS_W  (`SLD_VL_W + 1)                   // signed byte offset

`define SLD_SHFT_W  ($clog2(`SLD_CHUNK_B))            // byte shift within a chunk
`define SLD_CIDX_W  ($clog2(`SLD_CHUNKS))             // chunk index

`endif

// ==== sld_top.sv ====
//////////////////////////////////////////////////////////////////////
// vector slide unit, request in and finished destination vector out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module sld_top (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                req_valid_i,
    input  sld_pkg::sld_req_t   req_i,
    output logic                req_ready_o,
    output logic                res_valid_o,
    output sld_pkg::sld_res_t   res_o,
    input  logic                res_ready_i
);

    logic                   ctrl_valid, ctrl_ready;
    sld_pkg::sld_ctrl_t     ctrl;
    logic                   chunk_valid, chunk_ready;
    sld_pkg::sld_chunk_t    chunk;

    sld_decode i_decode (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .req_valid_i  ( req_valid_i  ),
        .req_i        ( req_i        ),
        .req_ready_o  ( req_ready_o  ),
        .ctrl_valid_o ( ctrl_valid   ),
        .ctrl_o       ( ctrl         ),
        .ctrl_ready_i ( ctrl_ready   )
    );

    sld_execute i_execute (
        .clk_i         ( clk_i        ),
        .async_rst_ni  ( async_rst_ni ),
        .ctrl_valid_i  ( ctrl_valid   ),
        .ctrl_i        ( ctrl         ),
        .ctrl_ready_o  ( ctrl_ready   ),
        .chunk_valid_o ( chunk_valid  ),
        .chunk_o       ( chunk        ),
        .chunk_ready_i ( chunk_ready  )
    );

    sld_result i_result (
        .clk_i         ( clk_i        ),
        .async_rst_ni  ( async_rst_ni ),
        .chunk_valid_i ( chunk_valid  ),
        .chunk_i       ( chunk        ),
        .chunk_ready_o ( chunk_ready  ),
        .res_valid_o   ( res_valid_o  ),
        .res_o         ( res_o        ),
        .res_ready_i   ( res_ready_i  )
    );

endmodule

// ==== tb_sld.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the vector slide unit, random and directed slides
// checked against an element-wise model of the slide rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "sld_settings.svh"

module tb_sld;

    localparam int TIMEOUT = 1000;                    // cycles per wait
    localparam int VB      = `SLD_VREG_W / 8;         // register bytes
    localparam int VLW     = `SLD_VL_W;

    logic                clk_i, async_rst_ni;
    logic                req_valid_i, req_ready_o;
    logic                res_valid_o, res_ready_i;
    sld_pkg::sld_req_t   req_i;
    sld_pkg::sld_res_t   res_o;
    sld_pkg::sld_req_t   pend_q[$];                   // requests waiting for their result
    logic                stall_mode;

    sld_top i_dut (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .req_valid_i  ( req_valid_i  ),
        .req_i        ( req_i        ),
        .req_ready_o  ( req_ready_o  ),
        .res_valid_o  ( res_valid_o  ),
        .res_o        ( res_o        ),
        .res_ready_i  ( res_ready_i  )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] get_elem(input logic [`SLD_VREG_W-1:0] v, input int e,
                                             input int i);
        logic [31:0] x;
        x = '0;
        for (int j = 0; j < e; j++) begin
            x[j*8 +: 8] = v[(i*e + j)*8 +: 8];
        end
        return x;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic sld_pkg::sld_res_t expected_vd(input sld_pkg::sld_req_t r);
        sld_pkg::sld_res_t res;
        int                e, vlmax;
        logic [31:0]       val;
        logic              write;
        e      = 1 << int'(r.eew);
        vlmax  = VB / e;
        res.vd = r.vd_old;
        for (int i = 0; i < vlmax; i++) begin
            write = (i < r.vl) && (!r.masked || r.v0[i*e]);   // tail and v0
            val   = '0;
            case (r.op)
                sld_pkg::SLIDEUP: begin
                    write = write && (longint'(r.scalar) <= i);
                    if (longint'(r.scalar) <= i) val = get_elem(r.vs2, e, i - int'(r.scalar));
                end
                sld_pkg::SLIDEDOWN: begin
                    if (longint'(r.scalar) + i < vlmax) val = get_elem(r.vs2, e, i + int'(r.scalar));
                end
                sld_pkg::SLIDE1UP: val = (i == 0) ? r.scalar : get_elem(r.vs2, e, i - 1);
                default: begin
                    if (i == int'(r.vl) - 1) val = r.scalar;
                    else if (i + 1 < vlmax) val = get_elem(r.vs2, e, i + 1);
                end
            endcase
            if (write) begin
                for (int j = 0; j < e; j++) res.vd[(i*e + j)*8 +: 8] = val[j*8 +: 8];
            end
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic report_elem_mismatch(input sld_pkg::sld_eew_e eew, input sld_pkg::sld_res_t got,
                                        input sld_pkg::sld_res_t exp, input string what);
        int e, first;
        e     = 1 << int'(eew);
        first = 0;
        for (int i = VB/e - 1; i >= 0; i--) begin
            if (get_elem(got.vd, e, i) !== get_elem(exp.vd, e, i)) first = i;
        end
        stop_on_error($sformatf("Fail at %0t: %s, %s element %0d is %h, expected %h", $time,
                      what, eew.name(), first, get_elem(got.vd, e, first),
                      get_elem(exp.vd, e, first)));
    endtask

    task automatic compare_res(input sld_pkg::sld_res_t got, input sld_pkg::sld_res_t exp,
                               input sld_pkg::sld_eew_e eew, input string what);
        if (got !== exp) report_elem_mismatch(eew, got, exp, what);
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus

    function automatic sld_pkg::sld_req_t random_req(input sld_pkg::sld_op_e op, input int eew,
                                                     input logic masked);
        sld_pkg::sld_req_t r;
        int                vlmax;
        logic [31:0]       rnd;
        vlmax    = VB >> eew;
        r.op     = op;
        r.eew    = sld_pkg::sld_eew_e'(eew);
        r.vl     = VLW'($urandom_range(0, vlmax));
        r.masked = masked;
        case ($urandom_range(0, 3))
            0:       r.scalar = '0;
            3:       r.scalar = $urandom;
            default: r.scalar = $urandom_range(0, vlmax + 2);
        endcase
        for (int w = 0; w < `SLD_VREG_W/32; w++) begin
            r.vs2[w*32 +: 32]    = $urandom;
            r.vd_old[w*32 +: 32] = $urandom;
        end
        rnd  = $urandom;
        r.v0 = rnd[VB-1:0];
        return r;
    endfunction

    task automatic send_req(input sld_pkg::sld_req_t r);
        int waited;
        waited      = 0;
        req_valid_i = 1'b1;
        req_i       = r;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT) stop_on_error("timeout, the request was never accepted");
        end while (!req_ready_o);
        pend_q.push_back(r);
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (pend_q.size() != 0) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) stop_on_error("timeout, a result never arrived");
        end
    endtask

    always @(negedge clk_i) begin
        res_ready_i <= stall_mode ? ($urandom_range(0, 2) != 0) : 1'b1;   // random back-pressure
    end

    //////////////////////////////////////////////////////////////////////
    // result checking

    initial begin
        sld_pkg::sld_res_t held;
        sld_pkg::sld_req_t r;
        logic              holding;
        holding = 1'b0;
        forever begin
            @(posedge clk_i);
            if (async_rst_ni) begin
                if (holding) begin
                    compare_bit(res_valid_o, 1'b1, "res_valid_o under back-pressure");
                    compare_res(res_o, held, sld_pkg::EEW_32, "stalled result");
                end
                holding = res_valid_o & ~res_ready_i;
                held    = res_o;
                if (res_valid_o && res_ready_i) begin
                    if (pend_q.size() == 0) begin
                        stop_on_error("a result arrived with no request outstanding");
                    end else begin
                        r = pend_q.pop_front();
                        compare_res(res_o, expected_vd(r), r.eew, $sformatf("%s", r.op.name()));
                    end
                end
            end
        end
    end

    initial begin
        sld_pkg::sld_req_t r;
        int                seed_val;
        seed_val     = $urandom(32'h2f31_56c8);
        stall_mode   = 1'b0;
        async_rst_ni = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        res_ready_i  = 1'b1;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;
        @(negedge clk_i);
        compare_bit(res_valid_o, 1'b0, "res_valid_o after reset");
        compare_bit(req_ready_o, 1'b1, "req_ready_o after reset");
        // unmasked slideup and slidedown corner offsets at each width
        for (int eew = 0; eew < 3; eew++) begin
            for (int op = 0; op < 2; op++) begin
                for (int c = 0; c < 5; c++) begin
                    r = random_req(sld_pkg::sld_op_e'(op), eew, 1'b0);
                    if (c == 0) r.scalar = '0;
                    if (c == 1) r.scalar = (VB >> eew) + $urandom_range(0, 20);   // past VLMAX
                    if (c == 2) r.vl = '0;
                    send_req(r);
                end
            end
        end
        // slide1 ops unmasked, then every op masked
        for (int op = 2; op < 4; op++) begin
            repeat (6) send_req(random_req(sld_pkg::sld_op_e'(op), $urandom_range(0, 2), 1'b0));
        end
        for (int op = 0; op < 4; op++) begin
            repeat (6) send_req(random_req(sld_pkg::sld_op_e'(op), $urandom_range(0, 2), 1'b1));
        end
        drain_results();
        // back-to-back stream, then the same with back-pressure
        for (int pass = 0; pass < 2; pass++) begin
            stall_mode = pass[0];
            repeat (50) send_req(random_req(sld_pkg::sld_op_e'($urandom_range(0, 3)),
                                            $urandom_range(0, 2), 1'($urandom_range(0, 1))));
            drain_results();
        end
        $display("All tests passed");
        $finish;
    end

endmodule
